/* verilog/p65Pkg.sv */
package p65Pkg;

  typedef logic [23:0] addrT;
  typedef logic [15:0] wordT;
  typedef logic [7:0]  byteT;
  // E N V M X D I Z C, carry in bit 0
  typedef logic [8:0]  statusT;
  typedef logic [2:0]  cycleT;

  typedef enum logic [1:0] {seqFetch, seqExec, seqIntEntry} seqStateT;
  typedef enum logic [1:0] {addrPc, addrStack, addrVector} addrSelT;
  typedef enum logic [1:0] {outNone, outPcHigh, outPcLow, outStatus} outSelT;
  typedef enum logic [2:0] {pHold, pFlagInstr, pXce, pRepSep, pIntEnter, pReset} pOpT;
  typedef enum logic {spHold, spDecrement} spOpT;
  typedef enum logic [1:0] {intReset, intNmi, intIrq} intKindT;

  // all-zero is an idle internal cycle at PC
  typedef struct packed {
    addrSelT addrSel;
    outSelT  outSel;
    pOpT     pOp;
    spOpT    spOp;
    logic    pcInc;
    logic    pcLoadLow;
    logic    pcLoadHigh;
    logic    vectorByte;
    logic    validProgram;
    logic    validData;
    logic    last;
  } cycleCtrlT;

  localparam byteT opClc = 8'h18;
  localparam byteT opSec = 8'h38;
  localparam byteT opCli = 8'h58;
  localparam byteT opSei = 8'h78;
  localparam byteT opClv = 8'hB8;
  localparam byteT opCld = 8'hD8;
  localparam byteT opSed = 8'hF8;
  localparam byteT opXce = 8'hFB;
  localparam byteT opRep = 8'hC2;
  localparam byteT opSep = 8'hE2;
  localparam byteT opPhp = 8'h08;
  localparam byteT opWai = 8'hCB;
  localparam byteT opStp = 8'hDB;
  localparam byteT opNop = 8'hEA;

  localparam statusT resetStatus = 9'b1_0011_0100;
  localparam byteT   stackPage   = 8'h01;
  localparam wordT   spReset     = 16'h0100;

  localparam wordT vecReset  = 16'hFFFC;
  localparam wordT vecNmiEmu = 16'hFFFA;
  localparam wordT vecNmiNat = 16'hFFEA;
  localparam wordT vecIrqEmu = 16'hFFFE;
  localparam wordT vecIrqNat = 16'hFFEE;

endpackage

/* verilog/p65Sequencer.sv */
`timescale 1ns/1ps

module p65Sequencer (
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              en,
  input  p65Pkg::byteT      dIn,
  input  logic              takeInt,
  output p65Pkg::byteT      ir,
  output p65Pkg::cycleCtrlT ctrl,
  output logic              waiDone,
  output logic              stpDone
);
  import p65Pkg::*;

  seqStateT seqState;
  cycleT    cycle;

  // ##################################################
  // state and cycle counter

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      seqState <= seqIntEntry;
      cycle    <= '0;
      ir       <= '0;
    end
    else if (en)
    begin
      if (seqState == seqFetch)
      begin
        cycle <= 3'd1;
        if (takeInt)
          seqState <= seqIntEntry;
        else
        begin
          seqState <= seqExec;
          ir       <= dIn;
        end
      end
      else if (ctrl.last)
      begin
        seqState <= seqFetch;
        cycle    <= '0;
      end
      else
        cycle <= cycle + 3'd1;
    end
  end

  // ##################################################
  // per-cycle control decode

  always_comb
  begin
    ctrl = '0;
    case (seqState)
      seqFetch:
      begin
        // doubles as the dummy fetch of interrupt entry
        ctrl.validProgram = 1'b1;
        ctrl.validData    = 1'b1;
        ctrl.pcInc        = !takeInt;
      end
      seqExec:
      begin
        if (ir == opRep || ir == opSep)
        begin
          if (cycle == 3'd1)
          begin
            ctrl.validProgram = 1'b1;
            ctrl.pcInc        = 1'b1;
          end
          else
          begin
            ctrl.pOp  = pRepSep;
            ctrl.last = 1'b1;
          end
        end
        else if (ir == opPhp)
        begin
          if (cycle == 3'd2)
          begin
            ctrl.addrSel   = addrStack;
            ctrl.outSel    = outStatus;
            ctrl.spOp      = spDecrement;
            ctrl.validData = 1'b1;
            ctrl.last      = 1'b1;
          end
        end
        else
        begin
          // implied, anything unknown runs as NOP
          ctrl.last = 1'b1;
          case (ir)
            opClc, opSec, opCli, opSei, opClv, opCld, opSed: ctrl.pOp = pFlagInstr;
            opXce: ctrl.pOp = pXce;
            default: ctrl.pOp = pHold;
          endcase
        end
      end
      default:
      begin
        case (cycle)
          // only reached straight out of reset
          3'd0:
          begin
            ctrl.validProgram = 1'b1;
            ctrl.validData    = 1'b1;
            ctrl.pOp          = pReset;
          end
          3'd1: ctrl.addrSel = addrPc;
          3'd2, 3'd3, 3'd4:
          begin
            ctrl.addrSel   = addrStack;
            ctrl.spOp      = spDecrement;
            ctrl.validData = 1'b1;
            if (cycle == 3'd2)
              ctrl.outSel = outPcHigh;
            else if (cycle == 3'd3)
              ctrl.outSel = outPcLow;
            else
            begin
              ctrl.outSel = outStatus;
              ctrl.pOp    = pIntEnter;
            end
          end
          3'd5:
          begin
            ctrl.addrSel   = addrVector;
            ctrl.validData = 1'b1;
            ctrl.pcLoadLow = 1'b1;
          end
          default:
          begin
            ctrl.addrSel    = addrVector;
            ctrl.validData  = 1'b1;
            ctrl.vectorByte = 1'b1;
            ctrl.pcLoadHigh = 1'b1;
            ctrl.last       = 1'b1;
          end
        endcase
      end
    endcase
  end

  assign waiDone = (seqState == seqExec) && (ir == opWai) && ctrl.last;
  assign stpDone = (seqState == seqExec) && (ir == opStp) && ctrl.last;

endmodule

/* verilog/p65StatusReg.sv */
`timescale 1ns/1ps

module p65StatusReg (
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              en,
  input  p65Pkg::cycleCtrlT ctrl,
  input  p65Pkg::byteT      ir,
  input  p65Pkg::byteT      dIn,
  output p65Pkg::statusT    status
);
  import p65Pkg::*;

  byteT operand;
  byteT repSepMask;

  // the operand fetch is the only cycle with VPA high and VDA low
  always_ff @(posedge CLK)
  begin
    if (en && ctrl.validProgram && !ctrl.validData)
      operand <= dIn;
  end

  // M and X stay untouched in emulation
  assign repSepMask = {operand[7:6], operand[5:4] & {2{~status[8]}}, operand[3:0]};

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
      status <= resetStatus;
    else if (en)
    begin
      case (ctrl.pOp)
        pFlagInstr:
        begin
          // bits 7:6 pick the flag, bit 5 the new value
          case (ir[7:6])
            2'b00: status[0] <= ir[5];
            2'b01: status[2] <= ir[5];
            2'b10: status[6] <= 1'b0;
            default: status[3] <= ir[5];
          endcase
        end
        pXce:
        begin
          status[8] <= status[0];
          status[0] <= status[8];
          if (status[0])
            status[5:4] <= 2'b11;
        end
        pRepSep:
        begin
          if (ir[5])
            status[7:0] <= status[7:0] | repSepMask;
          else
            status[7:0] <= status[7:0] & ~repSepMask;
        end
        pIntEnter:
        begin
          status[2] <= 1'b1;
          status[3] <= 1'b0;
        end
        pReset: status <= resetStatus;
        default: status <= status;
      endcase
    end
  end

endmodule

/* verilog/p65IntCtrl.sv */
`timescale 1ns/1ps

module p65IntCtrl (
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              RDY_IN,
  input  logic              NMI_N,
  input  logic              IRQ_N,
  input  logic              ABORT_N,
  input  p65Pkg::statusT    status,
  input  p65Pkg::cycleCtrlT ctrl,
  input  logic              waiDone,
  input  logic              stpDone,
  output logic              en,
  output logic              takeInt,
  output logic              RDY_OUT,
  output p65Pkg::intKindT   intKind
);
  import p65Pkg::*;

  logic nmiPrev;
  logic nmiPending;
  logic irqLow;
  logic waiting;
  logic stopped;
  logic accept;
  logic wake;
  logic decide;

  assign en      = RDY_IN && !waiting && !stopped;
  assign RDY_OUT = en;

  assign accept = nmiPending || (irqLow && !status[2]);
  // IRQ wakes WAI even when masked
  assign wake   = nmiPending || irqLow || !ABORT_N;
  assign decide = (en && ctrl.last) || (RDY_IN && waiting && wake);

  // ##################################################
  // NMI edge and IRQ level, sampled while halted too

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      nmiPrev    <= 1'b1;
      nmiPending <= 1'b0;
      irqLow     <= 1'b0;
    end
    else if (RDY_IN)
    begin
      nmiPrev <= NMI_N;
      irqLow  <= !IRQ_N;
      if (nmiPrev && !NMI_N)
        nmiPending <= 1'b1;
      else if (decide && nmiPending)
        nmiPending <= 1'b0;
    end
  end

  // ##################################################
  // acceptance and halting

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      takeInt <= 1'b0;
      intKind <= intReset;
      waiting <= 1'b0;
      stopped <= 1'b0;
    end
    else
    begin
      if (decide)
      begin
        takeInt <= accept;
        intKind <= nmiPending ? intNmi : intIrq;
      end
      else if (en)
        takeInt <= 1'b0;

      // an interrupt taken right at WAI skips the halt
      if (en && waiDone)
        waiting <= !accept;
      else if (decide)
        waiting <= 1'b0;

      if (en && stpDone)
        stopped <= 1'b1;
    end
  end

endmodule

/* verilog/p65BusUnit.sv */
`timescale 1ns/1ps

module p65BusUnit (
  input  logic              CLK,
  input  logic              RST_N,
  input  logic              en,
  input  p65Pkg::cycleCtrlT ctrl,
  input  p65Pkg::statusT    status,
  input  p65Pkg::intKindT   intKind,
  input  p65Pkg::byteT      dIn,
  output p65Pkg::addrT      aOut,
  output p65Pkg::byteT      dOut,
  output logic              we,
  output logic              vpa,
  output logic              vda,
  output logic              vpb
);
  import p65Pkg::*;

  wordT pc;
  wordT sp;
  byteT vecLow;
  wordT vecBase;
  logic emu;

  assign emu = status[8];

  // ##################################################
  // PC and SP

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      pc <= '0;
      sp <= spReset;
    end
    else if (en)
    begin
      if (ctrl.pcLoadHigh)
        pc <= {dIn, vecLow};
      else if (ctrl.pcInc)
        pc <= pc + 16'd1;

      // reset entry walks the stack cycles without moving SP
      if (ctrl.spOp == spDecrement && intKind != intReset)
      begin
        if (emu)
          sp[7:0] <= sp[7:0] - 8'd1;
        else
          sp <= sp - 16'd1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (en && ctrl.pcLoadLow)
      vecLow <= dIn;
  end

  // ##################################################
  // address and data out

  always_comb
  begin
    case (intKind)
      intNmi: vecBase = emu ? vecNmiEmu : vecNmiNat;
      intIrq: vecBase = emu ? vecIrqEmu : vecIrqNat;
      default: vecBase = vecReset;
    endcase
  end

  always_comb
  begin
    case (ctrl.addrSel)
      addrStack: aOut = emu ? {8'h00, stackPage, sp[7:0]} : {8'h00, sp};
      addrVector: aOut = {8'h00, vecBase[15:1], ctrl.vectorByte};
      default: aOut = {8'h00, pc};
    endcase
  end

  always_comb
  begin
    case (ctrl.outSel)
      outPcHigh: dOut = pc[15:8];
      outPcLow: dOut = pc[7:0];
      // B reads as 0 in an emulation interrupt frame
      outStatus: dOut = {status[7:5], status[4] & ~(emu && ctrl.pOp == pIntEnter), status[3:0]};
      default: dOut = 8'h00;
    endcase
  end

  assign we  = (ctrl.outSel == outNone) || (intKind == intReset);
  assign vpa = ctrl.validProgram;
  assign vda = ctrl.validData;
  assign vpb = (ctrl.addrSel != addrVector);

endmodule

/* verilog/p65Core.sv */
`timescale 1ns/1ps

module p65Core (
  input  logic         CLK,
  input  logic         RST_N,
  input  logic         RDY_IN,
  input  logic         NMI_N,
  input  logic         IRQ_N,
  input  logic         ABORT_N,
  input  p65Pkg::byteT D_IN,
  output p65Pkg::byteT D_OUT,
  output p65Pkg::addrT A_OUT,
  output logic         WE,
  output logic         RDY_OUT,
  output logic         VPA,
  output logic         VDA,
  output logic         VPB
);
  import p65Pkg::*;

  logic      en;
  logic      takeInt;
  logic      waiDone;
  logic      stpDone;
  intKindT   intKind;
  cycleCtrlT ctrl;
  byteT      ir;
  statusT    status;

  p65Sequencer sequencer_i (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .en      (en),
    .dIn     (D_IN),
    .takeInt (takeInt),
    .ir      (ir),
    .ctrl    (ctrl),
    .waiDone (waiDone),
    .stpDone (stpDone)
  );

  p65StatusReg statusReg_i (
    .CLK    (CLK),
    .RST_N  (RST_N),
    .en     (en),
    .ctrl   (ctrl),
    .ir     (ir),
    .dIn    (D_IN),
    .status (status)
  );

  p65IntCtrl intCtrl_i (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .RDY_IN  (RDY_IN),
    .NMI_N   (NMI_N),
    .IRQ_N   (IRQ_N),
    .ABORT_N (ABORT_N),
    .status  (status),
    .ctrl    (ctrl),
    .waiDone (waiDone),
    .stpDone (stpDone),
    .en      (en),
    .takeInt (takeInt),
    .RDY_OUT (RDY_OUT),
    .intKind (intKind)
  );

  p65BusUnit busUnit_i (
    .CLK     (CLK),
    .RST_N   (RST_N),
    .en      (en),
    .ctrl    (ctrl),
    .status  (status),
    .intKind (intKind),
    .dIn     (D_IN),
    .aOut    (A_OUT),
    .dOut    (D_OUT),
    .we      (WE),
    .vpa     (VPA),
    .vda     (VDA),
    .vpb     (VPB)
  );

endmodule

/* tb/p65Checker.sv */
`timescale 1ns/1ps

module p65Checker (
  input logic         CLK,
  input logic         RST_N,
  input logic         WE,
  input logic         VDA,
  input logic         VPB,
  input logic         RDY_OUT,
  input logic         stpDone,
  input p65Pkg::addrT A_OUT
);

  logic stopSeen;

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
      stopSeen <= 1'b0;
    else if (stpDone && RDY_OUT)
      stopSeen <= 1'b1;
  end

  writeHasVda: assert property (@(posedge CLK) disable iff (!RST_N) !WE |-> VDA)
    else $error("write cycle without VDA");

  vectorIsRead: assert property (@(posedge CLK) disable iff (!RST_N) !VPB |-> WE)
    else $error("vector cycle drives a write");

  stallHolds: assert property (@(posedge CLK) disable iff (!RST_N)
    !RDY_OUT |=> ($stable(A_OUT) && $stable(WE)))
    else $error("bus moved while RDY_OUT was low");

  stopHolds: assert property (@(posedge CLK) disable iff (!RST_N) stopSeen |-> !RDY_OUT)
    else $error("RDY_OUT rose after STP");

endmodule

bind p65Core p65Checker checker_i (
  .CLK     (CLK),
  .RST_N   (RST_N),
  .WE      (WE),
  .VDA     (VDA),
  .VPB     (VPB),
  .RDY_OUT (RDY_OUT),
  .stpDone (stpDone),
  .A_OUT   (A_OUT)
);

/* tb/p65Tb.sv */
`timescale 1ns/1ps

module p65Tb;
  import p65Pkg::*;

  localparam int streamCycles = 3000;
  localparam int intCycles    = 3000;
  localparam int stallCycles  = 2000;
  localparam int haltCycles   = 2000;
  localparam int stopLimit    = 500;
  localparam int afterStop    = 40;
  localparam int resetCycles  = 3;
  localparam int restartRun   = 20;
  localparam int totalCycles  = resetCycles * 2 + streamCycles + intCycles + stallCycles
                                + haltCycles + stopLimit + afterStop + restartRun;

  logic CLK;
  logic RST_N;
  logic RDY_IN;
  logic NMI_N;
  logic IRQ_N;
  logic ABORT_N;
  byteT D_IN;
  byteT D_OUT;
  addrT A_OUT;
  logic WE;
  logic RDY_OUT;
  logic VPA;
  logic VDA;
  logic VPB;

  p65Core dut_i (.*);

  logic [31:0] lfsr;
  string       testName;
  int          phase;
  logic        stpDue;
  logic        stepped;

  // reference model state
  seqStateT mState;
  cycleT    mCycle;
  byteT     mIr;
  byteT     mOperand;
  byteT     mVecLow;
  wordT     mPc;
  wordT     mSp;
  statusT   mStatus;
  intKindT  mKind;
  logic     mTake;
  logic     mWaiting;
  logic     mStopped;
  logic     mNmiPrev;
  logic     mNmiPend;
  logic     mIrqLow;

  // expected bus for the current cycle
  addrT eAddr;
  byteT eDout;
  logic eWe;
  logic eVpa;
  logic eVda;
  logic eVpb;
  logic eLast;

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial
  begin
    #(totalCycles * 10 * 2);
    $display("watchdog expired before the tests finished");
    $display("Test FAILED");
    $fatal(1);
  end

  // ##################################################
  // random numbers and memory contents

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic byteT nextOpcode();
    logic [3:0] r;
    r = 4'(randBits(4));
    if (stpDue)
      return opStp;
    case (r)
      4'd0: return opClc;
      4'd1: return opSec;
      4'd2: return opCli;
      4'd3: return opSei;
      4'd4: return opClv;
      4'd5: return opCld;
      4'd6: return opSed;
      4'd7: return opXce;
      4'd8: return opRep;
      4'd9: return opSep;
      4'd10, 4'd11: return opPhp;
      // WAI only where something can wake it
      4'd13: return (phase == 1 || phase == 3) ? opWai : opNop;
      default: return opNop;
    endcase
  endfunction

  function automatic byteT vectorTableByte(input addrT a);
    return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'hA5;
  endfunction

  // ##################################################
  // reference model

  function automatic addrT stackAddr();
    return mStatus[8] ? {8'h00, 8'h01, mSp[7:0]} : {8'h00, mSp};
  endfunction

  function automatic wordT vectorBase();
    case (mKind)
      intNmi: return mStatus[8] ? 16'hFFFA : 16'hFFEA;
      intIrq: return mStatus[8] ? 16'hFFFE : 16'hFFEE;
      default: return 16'hFFFC;
    endcase
  endfunction

  task automatic modelReset();
    mState   = seqIntEntry;
    mCycle   = 3'd0;
    mIr      = 8'h00;
    mPc      = 16'h0000;
    mSp      = 16'h0100;
    mStatus  = 9'b1_0011_0100;
    mKind    = intReset;
    mTake    = 1'b0;
    mWaiting = 1'b0;
    mStopped = 1'b0;
    mNmiPrev = 1'b1;
    mNmiPend = 1'b0;
    mIrqLow  = 1'b0;
  endtask

  task automatic predict();
    wordT base;
    base  = vectorBase();
    eAddr = {8'h00, mPc};
    eDout = 8'h00;
    eWe   = 1'b1;
    eVpa  = 1'b0;
    eVda  = 1'b0;
    eVpb  = 1'b1;
    eLast = 1'b0;
    if (mState == seqFetch)
    begin
      eVpa = 1'b1;
      eVda = 1'b1;
    end
    else if (mState == seqExec)
    begin
      if (mIr == opRep || mIr == opSep)
      begin
        eVpa  = (mCycle == 3'd1);
        eLast = (mCycle == 3'd2);
      end
      else if (mIr == opPhp)
      begin
        if (mCycle == 3'd2)
        begin
          eAddr = stackAddr();
          eWe   = 1'b0;
          eDout = mStatus[7:0];
          eVda  = 1'b1;
          eLast = 1'b1;
        end
      end
      else
        eLast = 1'b1;
    end
    else if (mCycle == 3'd0)
    begin
      eVpa = 1'b1;
      eVda = 1'b1;
    end
    else if (mCycle >= 3'd2 && mCycle <= 3'd4)
    begin
      eAddr = stackAddr();
      eWe   = (mKind == intReset);
      eVda  = 1'b1;
      if (mCycle == 3'd2)
        eDout = mPc[15:8];
      else if (mCycle == 3'd3)
        eDout = mPc[7:0];
      else
        eDout = {mStatus[7:5], mStatus[4] & ~mStatus[8], mStatus[3:0]};
    end
    else if (mCycle >= 3'd5)
    begin
      eAddr = {8'h00, base[15:1], mCycle == 3'd6};
      eVda  = 1'b1;
      eVpb  = 1'b0;
      eLast = (mCycle == 3'd6);
    end
  endtask

  task automatic pushDone();
    if (mKind != intReset)
    begin
      if (mStatus[8])
        mSp[7:0] = mSp[7:0] - 8'd1;
      else
        mSp = mSp - 16'd1;
    end
  endtask

  task automatic applyImplied();
    logic oldC;
    oldC = mStatus[0];
    case (mIr)
      opClc: mStatus[0] = 1'b0;
      opSec: mStatus[0] = 1'b1;
      opCli: mStatus[2] = 1'b0;
      opSei: mStatus[2] = 1'b1;
      opClv: mStatus[6] = 1'b0;
      opCld: mStatus[3] = 1'b0;
      opSed: mStatus[3] = 1'b1;
      opXce:
      begin
        mStatus[0] = mStatus[8];
        mStatus[8] = oldC;
        if (oldC)
          mStatus[5:4] = 2'b11;
      end
      default: mStatus = mStatus;
    endcase
  endtask

  task automatic step(input logic rdy, input logic nmiN, input logic irqN,
                      input logic abortN, input byteT din);
    logic en;
    logic decide;
    logic accept;
    logic waiEnd;
    logic stpEnd;
    byteT mask;
    predict();
    en      = rdy && !mWaiting && !mStopped;
    decide  = (en && eLast) || (rdy && mWaiting && (mNmiPend || mIrqLow || !abortN));
    accept  = mNmiPend || (mIrqLow && !mStatus[2]);
    waiEnd  = (mState == seqExec) && (mIr == opWai) && eLast;
    stpEnd  = (mState == seqExec) && (mIr == opStp) && eLast;
    stepped = en;
    if (en)
    begin
      if (mState == seqFetch)
      begin
        mCycle = 3'd1;
        if (mTake)
          mState = seqIntEntry;
        else
        begin
          mState = seqExec;
          mIr    = din;
          mPc    = mPc + 16'd1;
          if (din == opStp)
            stpDue = 1'b0;
        end
      end
      else
      begin
        if (mState == seqExec && (mIr == opRep || mIr == opSep))
        begin
          if (mCycle == 3'd1)
          begin
            mOperand = din;
            mPc      = mPc + 16'd1;
          end
          else
          begin
            mask = mOperand;
            if (mStatus[8])
              mask[5:4] = 2'b00;
            if (mIr == opSep)
              mStatus[7:0] = mStatus[7:0] | mask;
            else
              mStatus[7:0] = mStatus[7:0] & ~mask;
          end
        end
        else if (mState == seqExec && mIr == opPhp)
        begin
          if (mCycle == 3'd2)
            pushDone();
        end
        else if (mState == seqExec)
          applyImplied();
        else
        begin
          if (mCycle >= 3'd2 && mCycle <= 3'd4)
            pushDone();
          if (mCycle == 3'd4)
          begin
            mStatus[2] = 1'b1;
            mStatus[3] = 1'b0;
          end
          if (mCycle == 3'd5)
            mVecLow = din;
          if (mCycle == 3'd6)
            mPc = {din, mVecLow};
        end
        if (eLast)
        begin
          mState = seqFetch;
          mCycle = 3'd0;
        end
        else
          mCycle = mCycle + 3'd1;
      end
    end
    // interrupt unit updates the pending flag last so the kind sees the old one
    if (decide)
    begin
      mTake = accept;
      mKind = mNmiPend ? intNmi : intIrq;
    end
    else if (en)
      mTake = 1'b0;
    if (en && waiEnd)
      mWaiting = !accept;
    else if (decide)
      mWaiting = 1'b0;
    if (en && stpEnd)
      mStopped = 1'b1;
    if (rdy)
    begin
      if (mNmiPrev && !nmiN)
        mNmiPend = 1'b1;
      else if (decide && mNmiPend)
        mNmiPend = 1'b0;
      mNmiPrev = nmiN;
      mIrqLow  = !irqN;
    end
  endtask

  // ##################################################
  // compare tasks

  task automatic checkAddr(input string what, input addrT expected, input addrT actual);
    if (expected !== actual)
    begin
      $display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkByte(input string what, input byteT expected, input byteT actual);
    if (expected !== actual)
    begin
      $display("ERR %s %s: expected %h, actual %h", testName, what, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkBit(input string what, input logic expected, input logic actual);
    if (expected !== actual)
    begin
      $display("ERR %s %s: expected %b, actual %b", testName, what, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkOutputs();
    predict();
    checkAddr("A_OUT", eAddr, A_OUT);
    checkBit("WE", eWe, WE);
    checkBit("VPA", eVpa, VPA);
    checkBit("VDA", eVda, VDA);
    checkBit("VPB", eVpb, VPB);
    checkBit("RDY_OUT", RDY_IN && !mWaiting && !mStopped, RDY_OUT);
    if (!eWe)
      checkByte("D_OUT", eDout, D_OUT);
  endtask

  // ##################################################
  // stimulus

  task automatic driveInputs();
    RDY_IN  <= (phase == 2) ? (randBits(2) != 0) : 1'b1;
    ABORT_N <= (phase == 3) ? (randBits(4) != 0) : 1'b1;
    IRQ_N   <= (phase == 1 || phase == 2) ? (randBits(3) != 0) : 1'b1;
    if (phase == 1 || phase == 2)
      NMI_N <= (randBits(4) == 0) ? ~NMI_N : NMI_N;
    else if (phase == 3)
      NMI_N <= (randBits(6) == 0) ? ~NMI_N : NMI_N;
    else
      NMI_N <= 1'b1;
    if (stepped)
    begin
      predict();
      if (mState == seqFetch)
        D_IN <= nextOpcode();
      else if (mState == seqIntEntry && mCycle >= 3'd5)
        D_IN <= vectorTableByte(eAddr);
      else
        D_IN <= byteT'(randBits(8));
    end
  endtask

  task automatic runCycle();
    @(posedge CLK);
    stepped = 1'b0;
    if (RST_N)
      step(RDY_IN, NMI_N, IRQ_N, ABORT_N, D_IN);
    driveInputs();
    @(negedge CLK);
    checkOutputs();
  endtask

  task automatic applyReset();
    phase   = 0;
    RST_N   <= 1'b0;
    RDY_IN  <= 1'b1;
    NMI_N   <= 1'b1;
    IRQ_N   <= 1'b1;
    ABORT_N <= 1'b1;
    modelReset();
    repeat (resetCycles) @(posedge CLK);
    RST_N <= 1'b1;
    @(negedge CLK);
    checkOutputs();
  endtask

  initial
  begin
    int n;
    RST_N   <= 1'b0;
    RDY_IN  <= 1'b1;
    NMI_N   <= 1'b1;
    IRQ_N   <= 1'b1;
    ABORT_N <= 1'b1;
    D_IN    <= 8'h00;
    lfsr    = 32'h0cc2_47b0;
    stpDue  = 1'b0;
    stepped = 1'b0;
    testName = "reset";
    applyReset();

    testName = "stream";
    repeat (streamCycles) runCycle();
    testName = "interrupts";
    phase = 1;
    repeat (intCycles) runCycle();
    testName = "stall";
    phase = 2;
    repeat (stallCycles) runCycle();
    testName = "halt";
    phase = 3;
    repeat (haltCycles) runCycle();

    stpDue = 1'b1;
    n = 0;
    while (!mStopped && n < stopLimit)
    begin
      runCycle();
      n++;
    end
    if (!mStopped)
    begin
      $display("STP was not executed within %0d cycles", stopLimit);
      $display("Test FAILED");
      $fatal(1);
    end
    repeat (afterStop) runCycle();

    testName = "restart";
    @(posedge CLK);
    applyReset();
    repeat (restartRun) runCycle();

    $display("Test OK");
    $finish;
  end

endmodule

/* all.f */
verilog/p65Pkg.sv
verilog/p65Sequencer.sv
verilog/p65StatusReg.sv
verilog/p65IntCtrl.sv
verilog/p65BusUnit.sv
verilog/p65Core.sv
tb/p65Checker.sv
tb/p65Tb.sv

/* run.sh */
#!/bin/sh
# compile and run the p65Core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module p65Tb -o p65Sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/p65Sim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "simulator exited with status $simStatus"
  exit 1
fi
if ! grep -q "Test OK" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
